/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --top-module tb_rv_pipeline -f flist.f
	./obj_dir/Vtb_rv_pipeline | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing --top-module tb_rv_pipeline -f flist.f

clean:
	rm -rf obj_dir sim.log

/* flist.f */
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/rv_pipeline_top.sv
test/tb_rv_pipeline.sv

/* hw/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::word_t     if_id_pc,
  input  rv_pkg::word_t     if_id_instr,
  input  logic              stall,
  input  logic              bubble,
  input  logic              redirect,
  input  rv_pkg::wb_bus_t   wb,
  output rv_pkg::id_ex_t    id_ex,
  output rv_pkg::reg_addr_t rs1_d,
  output rv_pkg::reg_addr_t rs2_d
);

  logic [6:0]     opcode;
  rv_pkg::ctrl_t  ctrl;
  rv_pkg::word_t  imm;
  rv_pkg::word_t  rs1_val;
  rv_pkg::word_t  rs2_val;
  rv_pkg::id_ex_t id_ex_d;

  assign opcode = if_id_instr[6:0];
  assign rs1_d  = if_id_instr[19:15];
  assign rs2_d  = if_id_instr[24:20];

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs1     (rs1_d),
    .rs2     (rs2_d),
    .wb      (wb),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  // main decode, I-type immediate unless overridden
  always_comb begin
    ctrl = '0;
    imm  = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
    case (opcode)
      rv_pkg::op_load: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = rv_pkg::aluc_add;
      end
      rv_pkg::op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = rv_pkg::aluc_add;
        imm = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
      end
      rv_pkg::op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = rv_pkg::aluc_funct;
      end
      rv_pkg::op_reg, rv_pkg::op_custom0: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = rv_pkg::aluc_funct;
      end
      rv_pkg::op_branch: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = rv_pkg::aluc_sub;
        imm = {{20{if_id_instr[31]}}, if_id_instr[7], if_id_instr[30:25],
               if_id_instr[11:8], 1'b0};
      end
      rv_pkg::op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        imm = {{12{if_id_instr[31]}}, if_id_instr[19:12], if_id_instr[20],
               if_id_instr[30:21], 1'b0};
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  assign id_ex_d = '{
    ctrl:    ctrl,
    pc:      if_id_pc,
    rs1_val: rs1_val,
    rs2_val: rs2_val,
    imm:     imm,
    rs1:     rs1_d,
    rs2:     rs2_d,
    rd:      if_id_instr[11:7],
    funct3:  if_id_instr[14:12],
    funct7:  if_id_instr[31:25],
    opcode:  opcode
  };

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (redirect || bubble) begin
      // kill whatever enters EX, only the controls matter
      id_ex.ctrl <= '0;
    end else if (!stall) begin
      id_ex <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::id_ex_t  id_ex,
  input  logic [1:0]      fwd_a,
  input  logic [1:0]      fwd_b,
  input  rv_pkg::wb_bus_t wb,
  output rv_pkg::ex_mem_t ex_mem,
  output logic            redirect,
  output rv_pkg::word_t   target
);

  rv_pkg::word_t   op_a;
  rv_pkg::word_t   rs2_fwd;
  rv_pkg::word_t   op_b;
  rv_pkg::word_t   alu_out;
  rv_pkg::alu_op_e alu_sel;
  logic            taken;

  function automatic rv_pkg::alu_op_e alu_decode(input logic [1:0] cls,
                                                 input logic [2:0] f3,
                                                 input logic [6:0] f7,
                                                 input logic [6:0] opc);
    rv_pkg::alu_op_e sel;
    sel = rv_pkg::alu_add;
    if (opc == rv_pkg::op_custom0) begin
      case ({f7[1:0], f3})
        5'b00_000: sel = rv_pkg::alu_andn;
        5'b00_001: sel = rv_pkg::alu_orn;
        5'b00_010: sel = rv_pkg::alu_xnor;
        5'b01_000: sel = rv_pkg::alu_min;
        5'b01_001: sel = rv_pkg::alu_max;
        5'b01_010: sel = rv_pkg::alu_minu;
        5'b01_011: sel = rv_pkg::alu_maxu;
        5'b10_000: sel = rv_pkg::alu_rol;
        5'b10_001: sel = rv_pkg::alu_ror;
        5'b11_000: sel = rv_pkg::alu_abs;
        default:   sel = rv_pkg::alu_add;
      endcase
    end else if (cls == rv_pkg::aluc_sub) begin
      sel = rv_pkg::alu_sub;
    end else if (cls == rv_pkg::aluc_funct) begin
      case (f3)
        // addi has no sub form, its imm bit 30 is just data
        3'b000:  sel = (opc == rv_pkg::op_reg && f7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
        3'b001:  sel = rv_pkg::alu_sll;
        3'b010:  sel = rv_pkg::alu_slt;
        3'b011:  sel = rv_pkg::alu_sltu;
        3'b100:  sel = rv_pkg::alu_xor;
        3'b101:  sel = f7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        3'b110:  sel = rv_pkg::alu_or;
        default: sel = rv_pkg::alu_and;
      endcase
    end
    return sel;
  endfunction

  function automatic rv_pkg::word_t alu(input rv_pkg::word_t a, input rv_pkg::word_t b,
                                        input rv_pkg::alu_op_e sel);
    logic [63:0] dbl;
    logic [4:0]  sh;
    logic        lts;
    logic        ltu;
    dbl = {a, a};
    sh  = b[4:0];
    lts = $signed(a) < $signed(b);
    ltu = a < b;
    case (sel)
      rv_pkg::alu_add:  return a + b;
      rv_pkg::alu_sub:  return a - b;
      rv_pkg::alu_and:  return a & b;
      rv_pkg::alu_or:   return a | b;
      rv_pkg::alu_xor:  return a ^ b;
      rv_pkg::alu_slt:  return {31'd0, lts};
      rv_pkg::alu_sltu: return {31'd0, ltu};
      rv_pkg::alu_sll:  return a << sh;
      rv_pkg::alu_srl:  return a >> sh;
      rv_pkg::alu_sra:  return $signed(a) >>> sh;
      rv_pkg::alu_andn: return a & ~b;
      rv_pkg::alu_orn:  return a | ~b;
      rv_pkg::alu_xnor: return ~(a ^ b);
      rv_pkg::alu_min:  return lts ? a : b;
      rv_pkg::alu_max:  return lts ? b : a;
      rv_pkg::alu_minu: return ltu ? a : b;
      rv_pkg::alu_maxu: return ltu ? b : a;
      // rotates via the doubled word
      rv_pkg::alu_rol:  return dbl[63-sh -: 32];
      rv_pkg::alu_ror:  return dbl[sh +: 32];
      rv_pkg::alu_abs:  return a[31] ? -a : a;
      default:          return a + b;
    endcase
  endfunction

  always_comb begin
    case (fwd_a)
      rv_pkg::fwd_mem: op_a = ex_mem.alu_out;
      rv_pkg::fwd_wb:  op_a = wb.value;
      default:         op_a = id_ex.rs1_val;
    endcase
    case (fwd_b)
      rv_pkg::fwd_mem: rs2_fwd = ex_mem.alu_out;
      rv_pkg::fwd_wb:  rs2_fwd = wb.value;
      default:         rs2_fwd = id_ex.rs2_val;
    endcase
  end

  assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;
  assign alu_sel = alu_decode(id_ex.ctrl.alu_op, id_ex.funct3, id_ex.funct7, id_ex.opcode);
  assign alu_out = alu(op_a, op_b, alu_sel);

  // branch comparator on forwarded operands
  always_comb begin
    case (id_ex.funct3)
      rv_pkg::f3_beq:  taken = op_a == rs2_fwd;
      rv_pkg::f3_bne:  taken = op_a != rs2_fwd;
      rv_pkg::f3_blt:  taken = $signed(op_a) < $signed(rs2_fwd);
      rv_pkg::f3_bge:  taken = $signed(op_a) >= $signed(rs2_fwd);
      rv_pkg::f3_bltu: taken = op_a < rs2_fwd;
      rv_pkg::f3_bgeu: taken = op_a >= rs2_fwd;
      default:         taken = 1'b0;
    endcase
  end

  assign redirect = (id_ex.ctrl.branch && taken) || id_ex.ctrl.jump;
  assign target   = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      // jal links pc plus 4
      ex_mem.alu_out    <= id_ex.ctrl.jump ? id_ex.pc + 32'd4 : alu_out;
      ex_mem.store_data <= rs2_fwd;
      ex_mem.rd         <= id_ex.rd;
    end
  end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall,
  input  logic          redirect,
  input  rv_pkg::word_t target,
  input  rv_pkg::word_t instr,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t if_id_pc,
  output rv_pkg::word_t if_id_instr
);

  rv_pkg::word_t pc_next;

  // redirect wins over a load-use stall
  assign pc_next = redirect ? target : pc + 32'd4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect || !stall) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_id_pc    <= '0;
      if_id_instr <= rv_pkg::nop_instr;
    end else if (redirect) begin
      // squash the wrong-path fetch
      if_id_pc    <= '0;
      if_id_instr <= rv_pkg::nop_instr;
    end else if (!stall) begin
      if_id_pc    <= pc;
      if_id_instr <= instr;
    end
  end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  rv_pkg::id_ex_t    id_ex,
  input  rv_pkg::reg_addr_t rs1_d,
  input  rv_pkg::reg_addr_t rs2_d,
  input  rv_pkg::ex_mem_t   ex_mem,
  input  rv_pkg::wb_bus_t   wb,
  output logic              stall,
  output logic              bubble,
  output logic [1:0]        fwd_a,
  output logic [1:0]        fwd_b
);

  logic load_use;
  logic mem_hit_a;
  logic mem_hit_b;
  logic wb_hit_a;
  logic wb_hit_b;

  // load in EX feeding the instruction in ID
  assign load_use = id_ex.ctrl.mem_to_reg && id_ex.rd != 5'd0 &&
                    (id_ex.rd == rs1_d || id_ex.rd == rs2_d);
  assign stall  = load_use;
  assign bubble = load_use;

  assign mem_hit_a = ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == id_ex.rs1;
  assign mem_hit_b = ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == id_ex.rs2;
  assign wb_hit_a  = wb.we && wb.rd != 5'd0 && wb.rd == id_ex.rs1;
  assign wb_hit_b  = wb.we && wb.rd != 5'd0 && wb.rd == id_ex.rs2;

  // youngest producer first
  assign fwd_a = mem_hit_a ? rv_pkg::fwd_mem : (wb_hit_a ? rv_pkg::fwd_wb : rv_pkg::fwd_none);
  assign fwd_b = mem_hit_b ? rv_pkg::fwd_mem : (wb_hit_b ? rv_pkg::fwd_wb : rv_pkg::fwd_none);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::wb_bus_t   wb,
  output rv_pkg::word_t     rs1_val,
  output rv_pkg::word_t     rs2_val
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // x0 reads zero, a same-cycle write is passed through
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_val = '0;
    end else if (wb.we && wb.rd == rs1) begin
      rs1_val = wb.value;
    end else begin
      rs1_val = regs[rs1];
    end
    if (rs2 == 5'd0) begin
      rs2_val = '0;
    end else if (wb.we && wb.rd == rs2) begin
      rs2_val = wb.value;
    end else begin
      rs2_val = regs[rs2];
    end
  end

endmodule

`default_nettype wire

/* hw/rv_pipeline_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_pipeline_top (
  input  logic          clk,
  input  logic          reset,
  input  rv_pkg::word_t instr,
  input  rv_pkg::word_t read_data,
  output rv_pkg::word_t pc,
  output logic          mem_write,
  output rv_pkg::word_t data_addr,
  output rv_pkg::word_t write_data
);

  rv_pkg::word_t     if_id_pc;
  rv_pkg::word_t     if_id_instr;
  rv_pkg::id_ex_t    id_ex;
  rv_pkg::ex_mem_t   ex_mem;
  rv_pkg::wb_bus_t   wb;
  rv_pkg::reg_addr_t rs1_d;
  rv_pkg::reg_addr_t rs2_d;
  rv_pkg::word_t     target;
  logic              redirect;
  logic              stall;
  logic              bubble;
  logic [1:0]        fwd_a;
  logic [1:0]        fwd_b;

  fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .target      (target),
    .instr       (instr),
    .pc          (pc),
    .if_id_pc    (if_id_pc),
    .if_id_instr (if_id_instr)
  );

  decode_stage u_decode (
    .clk         (clk),
    .reset       (reset),
    .if_id_pc    (if_id_pc),
    .if_id_instr (if_id_instr),
    .stall       (stall),
    .bubble      (bubble),
    .redirect    (redirect),
    .wb          (wb),
    .id_ex       (id_ex),
    .rs1_d       (rs1_d),
    .rs2_d       (rs2_d)
  );

  hazard_unit u_hazard (
    .id_ex  (id_ex),
    .rs1_d  (rs1_d),
    .rs2_d  (rs2_d),
    .ex_mem (ex_mem),
    .wb     (wb),
    .stall  (stall),
    .bubble (bubble),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .wb       (wb),
    .ex_mem   (ex_mem),
    .redirect (redirect),
    .target   (target)
  );

  writeback_stage u_writeback (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .read_data (read_data),
    .wb        (wb)
  );

  // data memory port straight from EX/MEM
  assign mem_write  = ex_mem.mem_write;
  assign data_addr  = ex_mem.alu_out;
  assign write_data = ex_mem.store_data;

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // addi x0,x0,0
  localparam word_t nop_instr = 32'h0000_0013;

  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_imm     = 7'b0010011;
  localparam logic [6:0] op_reg     = 7'b0110011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_custom0 = 7'b0001011;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // alu_op class carried in ctrl_t
  localparam logic [1:0] aluc_add   = 2'b00;
  localparam logic [1:0] aluc_sub   = 2'b01;
  localparam logic [1:0] aluc_funct = 2'b10;

  // forwarding selects
  localparam logic [1:0] fwd_none = 2'b00;
  localparam logic [1:0] fwd_mem  = 2'b01;
  localparam logic [1:0] fwd_wb   = 2'b10;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
    alu_andn, alu_orn, alu_xnor, alu_min, alu_max,
    alu_minu, alu_maxu, alu_rol, alu_ror, alu_abs
  } alu_op_e;

  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    logic       mem_to_reg;
    logic       alu_src;
    logic       branch;
    logic       jump;
    logic [1:0] alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t      ctrl;
    word_t      pc;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] opcode;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_write;
    logic      mem_to_reg;
    word_t     alu_out;
    word_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  // register write port, also the late forwarding source
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     value;
  } wb_bus_t;

endpackage

`default_nettype wire

/* hw/writeback_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::ex_mem_t ex_mem,
  input  rv_pkg::word_t   read_data,
  output rv_pkg::wb_bus_t wb
);

  logic              reg_write_q;
  logic              mem_to_reg_q;
  rv_pkg::reg_addr_t rd_q;
  rv_pkg::word_t     alu_q;
  rv_pkg::word_t     load_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_write_q  <= 1'b0;
      mem_to_reg_q <= 1'b0;
      rd_q         <= '0;
    end else begin
      reg_write_q  <= ex_mem.reg_write;
      mem_to_reg_q <= ex_mem.mem_to_reg;
      rd_q         <= ex_mem.rd;
    end
  end

  always_ff @(posedge clk) begin
    alu_q  <= ex_mem.alu_out;
    load_q <= read_data;
  end

  // no write and no forwarding for x0
  assign wb.we    = reg_write_q && rd_q != 5'd0;
  assign wb.rd    = rd_q;
  assign wb.value = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

/* test/rv_stim.txt */
# kind addr value: p = program word at byte addr, d = data preload, e = expected store
p 000 00500093
p 004 00308113
p 008 002081b3
p 00c 40118233
p 010 10202023
p 014 10302223
p 018 10402423
p 01c 18002283
p 020 00128313
p 024 10502623
p 028 10602823
p 02c 18402383
p 030 10702a23
p 034 04d00013
p 038 10002c23
p 03c fff00413
p 040 00409493
p 044 01c45513
p 048 0ff4c593
p 04c 10b02e23
p 050 00142633
p 054 00c516b3
p 058 12d02023
# taken branches, each skips a wrong-path store
p 05c 00108463
p 060 1e802e23
p 064 00209463
p 068 1e802e23
p 06c 00144463
p 070 1e802e23
p 074 0080d463
p 078 1e802e23
p 07c 0080e463
p 080 1e802e23
p 084 00147463
p 088 1e802e23
# not-taken branches, each followed by a counter increment
p 08c 00208463
p 090 00170713
p 094 00109463
p 098 00170713
p 09c 0080c463
p 0a0 00170713
p 0a4 00145463
p 0a8 00170713
p 0ac 00146463
p 0b0 00170713
p 0b4 0080f463
p 0b8 00170713
p 0bc 12e02223
p 0c0 008007ef
p 0c4 1e802e23
p 0c8 12f02423
# custom-0 ops on 0x80000001 and 5, each stored at once
p 0cc 0013880b
p 0d0 13002623
p 0d4 0013988b
p 0d8 13102823
p 0dc 0013a90b
p 0e0 13202a23
p 0e4 0213898b
p 0e8 13302c23
p 0ec 02139a0b
p 0f0 13402e23
p 0f4 0213aa8b
p 0f8 15502023
p 0fc 0213bb0b
p 100 15602223
p 104 04138b8b
p 108 15702423
p 10c 04139c0b
p 110 15802623
p 114 06038c8b
p 118 15902823
p 11c 0000006f
d 180 12345678
d 184 80000001
e 100 00000008
e 104 0000000d
e 108 00000008
e 10c 12345678
e 110 12345679
e 114 80000001
e 118 00000000
e 11c 000000af
e 120 0000001e
e 124 00000006
e 128 000000c4
e 12c 80000000
e 130 fffffffb
e 134 7ffffffb
e 138 80000001
e 13c 00000005
e 140 00000005
e 144 80000001
e 148 00000030
e 14c 0c000000
e 150 7fffffff

/* test/tb_rv_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_pipeline;

  logic          clk;
  logic          reset;
  rv_pkg::word_t instr;
  rv_pkg::word_t read_data;
  rv_pkg::word_t pc;
  logic          mem_write;
  rv_pkg::word_t data_addr;
  rv_pkg::word_t write_data;

  rv_pkg::word_t imem [256];
  rv_pkg::word_t dmem [256];
  rv_pkg::word_t exp_addr [$];
  rv_pkg::word_t exp_data [$];

  int errors;
  int exp_idx;
  int cycles;

  rv_pipeline_top UUT (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .read_data  (read_data),
    .pc         (pc),
    .mem_write  (mem_write),
    .data_addr  (data_addr),
    .write_data (write_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // records are: kind (p program, d data preload, e expected store), address, value
  task automatic load_stim();
    int            fd;
    int            n;
    string         line;
    byte           kind;
    rv_pkg::word_t a;
    rv_pkg::word_t v;
    fd = $fopen("test/rv_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file test/rv_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h", kind, a, v);
          if (n == 3) begin
            case (kind)
              "p": imem[a[9:2]] = v;
              "d": dmem[a[9:2]] = v;
              "e": begin
                exp_addr.push_back(a);
                exp_data.push_back(v);
              end
              default: ;
            endcase
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_state();
    if (pc !== 32'd0) begin
      $display("** Error at %0t: pc expected %h got %h", $time, 32'd0, pc);
      errors++;
    end
    if (mem_write !== 1'b0) begin
      $display("** Error at %0t: mem_write expected 0 got %b", $time, mem_write);
      errors++;
    end
  endtask

  // store port: update data memory and compare against the expected list
  task automatic handle_store();
    if (mem_write === 1'b1) begin
      dmem[data_addr[9:2]] = write_data;
      if (exp_idx >= exp_addr.size()) begin
        $display("unexpected store of %h to address %h at %0t", write_data, data_addr, $time);
        errors++;
      end else begin
        if (data_addr !== exp_addr[exp_idx]) begin
          $display("** Error at %0t: data_addr expected %h got %h",
                   $time, exp_addr[exp_idx], data_addr);
          errors++;
        end
        if (write_data !== exp_data[exp_idx]) begin
          $display("** Error at %0t: write_data expected %h got %h",
                   $time, exp_data[exp_idx], write_data);
          errors++;
        end
        exp_idx++;
      end
    end
  endtask

  task automatic drive_memories();
    instr     = imem[pc[9:2]];
    read_data = dmem[data_addr[9:2]];
  endtask

  task automatic step();
    @(posedge clk);
    #1;
    handle_store();
    drive_memories();
  endtask

  initial begin
    errors    = 0;
    exp_idx   = 0;
    cycles    = 0;
    reset     = 1'b1;
    instr     = rv_pkg::nop_instr;
    read_data = '0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = rv_pkg::nop_instr;
      dmem[i] = 32'hd0d0_0000 | (i << 2);
    end
    load_stim();

    repeat (8) begin
      @(posedge clk);
      #1;
      check_reset_state();
      drive_memories();
    end
    reset = 1'b0;
    // first fetch still at pc 0
    check_reset_state();

    while (exp_idx < exp_addr.size() && cycles < 2000) begin
      step();
      cycles++;
    end
    if (exp_idx < exp_addr.size()) begin
      $display("timeout after %0d cycles with %0d of %0d stores seen",
               cycles, exp_idx, exp_addr.size());
      errors++;
    end

    // watch for stray stores while the program spins
    repeat (100) begin
      step();
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
